//--- Bender.yml
package:
  name: decode_stage

sources:
  - src/rv_isa_pkg.sv
  - src/rv_csr_pkg.sv
  - src/inst_decoder.sv
  - src/gpr_file.sv
  - src/csr_file.sv
  - src/decode_stage.sv
  - target: simulation
    files:
      - sim/decode_stage_sva.sv
      - sim/decode_stage_tb.sv

//--- sim/decode_stage_sva.sv
`timescale 1ns/100ps

module decode_stage_sva (
    input logic                              clk,
    input logic                              rst_n,
    input logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
    input logic [rv_isa_pkg::xlen-1:0]       src1,
    input logic                              is_intr,
    input logic [rv_isa_pkg::xlen-1:0]       pc,
    input logic [rv_isa_pkg::xlen-1:0]       mepc,
    input logic [rv_isa_pkg::xlen-1:0]       csr_r
);

    int failures = 0;  // failed checks so far

    // x0 on the operand port
    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (src1 == '0))
        else begin
            failures++;
            $error("src1 is not zero while rs1 selects x0");
        end

    intr_captures_pc: assert property (@(posedge clk) disable iff (!rst_n)
        is_intr |=> (mepc == $past(pc)))
        else begin
            failures++;
            $error("mepc did not take pc after an interrupt");
        end

    csr_r_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(csr_r))
        else begin
            failures++;
            $error("csr_r holds x or z bits");
        end

endmodule

// csr_file sees rs1 and the register file's src1 as well
bind csr_file decode_stage_sva decode_stage_sva_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs1    (rs1),
    .src1   (src1),
    .is_intr(is_intr),
    .pc     (pc),
    .mepc   (mepc),
    .csr_r  (csr_r)
);

//--- sim/decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 5;
    localparam int max_vectors  = 64;
    localparam int n_cols       = 14;
    localparam string vector_path = "sim/decode_vectors.txt";

    // column order of a vector line
    localparam int c_inst      = 0;
    localparam int c_pc        = 1;
    localparam int c_srd       = 2;
    localparam int c_gpr_w_en  = 3;
    localparam int c_csr_w_en  = 4;
    localparam int c_is_intr   = 5;
    localparam int c_intr_code = 6;
    localparam int c_type      = 7;
    localparam int c_imm       = 8;
    localparam int c_src1      = 9;
    localparam int c_src2      = 10;
    localparam int c_csr_r     = 11;
    localparam int c_mepc      = 12;
    localparam int c_mtvec     = 13;

    logic                            clk;
    logic                            rst_n;
    logic [rv_isa_pkg::xlen-1:0]     inst;
    logic [rv_isa_pkg::xlen-1:0]     pc;
    logic [rv_isa_pkg::xlen-1:0]     srd;
    logic                            gpr_w_en;
    logic                            csr_w_en;
    logic                            is_intr;
    logic [rv_isa_pkg::xlen-1:0]     intr_code;
    rv_isa_pkg::inst_type_e          inst_type;
    logic [rv_isa_pkg::xlen-1:0]     imm;
    logic [rv_isa_pkg::opcode_w-1:0] opcode;
    logic [rv_isa_pkg::funct3_w-1:0] funct3;
    logic [rv_isa_pkg::funct7_w-1:0] funct7;
    logic [rv_isa_pkg::xlen-1:0]     src1;
    logic [rv_isa_pkg::xlen-1:0]     src2;
    logic [rv_isa_pkg::xlen-1:0]     csr_r;
    logic [rv_isa_pkg::xlen-1:0]     mepc;
    logic [rv_isa_pkg::xlen-1:0]     mtvec;

    logic [rv_isa_pkg::xlen-1:0] vecs [0:max_vectors-1][0:n_cols-1];
    int      n_vec;
    int      errors;
    realtime watchdog_ns = 0;

    decode_stage decode_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_type(input rv_isa_pkg::inst_type_e exp,
                              input rv_isa_pkg::inst_type_e act);
        if (act !== exp) begin
            errors++;
            $display("error at %t: inst_type expected %s (%0d) got %s (%0d)",
                     $realtime, exp.name(), exp, act.name(), act);
        end
    endtask

    task automatic check_word(input string name, input logic [rv_isa_pkg::xlen-1:0] exp,
                              input logic [rv_isa_pkg::xlen-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("error at %t: %s expected %h got %h", $realtime, name, exp, act);
        end
    endtask

    task automatic check_field(input string name, input logic [rv_isa_pkg::funct7_w-1:0] exp,
                               input logic [rv_isa_pkg::funct7_w-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("error at %t: %s expected %h got %h", $realtime, name, exp, act);
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    n;
        int    line_no;
        string line;
        logic [rv_isa_pkg::xlen-1:0] f [0:n_cols-1];
        fd = $fopen(vector_path, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", vector_path);
            errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd) && n_vec < max_vectors) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() == 0 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (n <= 0) continue;  // blank line
            if (n < n_cols) begin
                $display("vector file line %0d holds only %0d of %0d fields", line_no, n, n_cols);
                errors++;
                break;
            end
            for (int k = 0; k < n_cols; k++) begin
                vecs[n_vec][k] = f[k];
            end
            n_vec++;
        end
        $fclose(fd);
        if (n_vec == 0 && errors == 0) begin
            $display("no vectors found in %s", vector_path);
            errors++;
        end
    endtask

    task automatic apply_vector(input int v);
        inst      = vecs[v][c_inst];
        pc        = vecs[v][c_pc];
        srd       = vecs[v][c_srd];
        gpr_w_en  = vecs[v][c_gpr_w_en][0];
        csr_w_en  = vecs[v][c_csr_w_en][0];
        is_intr   = vecs[v][c_is_intr][0];
        intr_code = vecs[v][c_intr_code];
    endtask

    // enables low, so random pc and srd leave the state alone
    task automatic apply_filler();
        inst      = '0;
        pc        = $urandom();
        srd       = $urandom();
        gpr_w_en  = 1'b0;
        csr_w_en  = 1'b0;
        is_intr   = 1'b0;
        intr_code = '0;
    endtask

    task automatic check_vector(input int v);
        logic [rv_isa_pkg::xlen-1:0] word;
        word = vecs[v][c_inst];
        check_type(rv_isa_pkg::inst_type_e'(vecs[v][c_type][2:0]), inst_type);
        check_word("imm", vecs[v][c_imm], imm);
        // rv32i field layout of the applied instruction
        check_field("opcode", word[6:0], opcode);
        check_field("funct3", {4'b0, word[14:12]}, {4'b0, funct3});
        check_field("funct7", word[31:25], funct7);
        check_word("src1", vecs[v][c_src1], src1);
        check_word("src2", vecs[v][c_src2], src2);
        check_word("csr_r", vecs[v][c_csr_r], csr_r);
        check_word("mepc", vecs[v][c_mepc], mepc);
        check_word("mtvec", vecs[v][c_mtvec], mtvec);
    endtask

    initial begin
        void'($urandom(72749));
        $timeformat(-9, 1, " ns", 0);
        rst_n  = 1'b0;
        errors = 0;
        n_vec  = 0;
        apply_filler();
        pc  = '0;
        srd = '0;
        read_vectors();
        if (errors == 0) begin
            watchdog_ns = (2 * n_vec + reset_cycles + 20) * clk_period;
            repeat (reset_cycles) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int v = 0; v < n_vec; v++) begin
                apply_vector(v);
                #1;  // outputs settled, next rising edge still ahead
                check_vector(v);
                @(negedge clk);
                apply_filler();
                @(negedge clk);
            end
        end
        errors += decode_stage_i.csr_file_i.decode_stage_sva_i.failures;
        $display("%0d errors over %0d vectors", errors, n_vec);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired at %t before the vectors were done", $realtime);
        $display("test failed");
        $finish;
    end

endmodule

//--- sim/decode_vectors.txt
# inst pc srd gpr_w_en csr_w_en is_intr intr_code, then expected inst_type imm src1 src2 csr_r mepc mtvec
# inst_type 0 r, 1 i, 2 s, 3 b, 4 u, 5 j, 7 none; expected values hold before the rising edge
002081b3 0 0 0 0 0 0  0 0 0 0 0 0 0  # add x3, x1, x2 right after reset
30002073 0 0 0 0 0 0  1 300 0 0 0 0 0
800000b7 0 0 0 0 0 0  4 80000000 0 0 0 0 0  # lui
12345117 0 0 0 0 0 0  4 12345000 0 0 0 0 0
ffdff0ef 0 0 0 0 0 0  5 fffffffc 0 0 0 0 0  # jal -4
ff8100e7 0 0 0 0 0 0  1 fffffff8 0 0 0 0 0
fe2088e3 0 0 0 0 0 0  3 fffffff0 0 0 0 0 0  # beq -16
ffc0a183 0 0 0 0 0 0  1 fffffffc 0 0 0 0 0
fe20aa23 0 0 0 0 0 0  2 fffffff4 0 0 0 0 0  # sw -12
7ff00093 0 0 0 0 0 0  1 7ff 0 0 0 0 0
ffffffff 0 0 0 0 0 0  7 0 0 0 0 0 0  # unknown opcode
00000293 0 12345678 1 0 0 0  1 0 0 0 0 0 0  # x5 write
00000313 0 cafef00d 1 0 0 0  1 0 0 0 0 0 0
006283b3 0 0 0 0 0 0  0 0 12345678 cafef00d 0 0 0
00000293 0 deadbeef 0 0 0 0  1 0 0 0 0 0 0  # write enable low
00000013 0 ffffffff 1 0 0 0  1 0 0 0 0 0 0  # x0 write
40028433 0 0 0 0 0 0  0 0 12345678 0 0 0 0
30529073 0 0 0 1 0 0  1 305 12345678 12345678 0 0 0  # csrrw mtvec, x5
30532073 0 0 0 1 0 0  1 305 cafef00d 12345678 12345678 0 12345678
3052b073 0 0 0 1 0 0  1 305 12345678 12345678 dafef67d 0 dafef67d
3002d073 0 0 0 1 0 0  1 300 12345678 0 0 0 c8caa005  # csrrwi mstatus, 5
30036073 0 0 0 1 0 0  1 300 cafef00d 0 5 0 c8caa005
3002f073 0 0 0 1 0 0  1 300 12345678 0 7 0 c8caa005
30002073 0 0 0 0 0 0  1 300 0 0 2 0 c8caa005
7c029073 0 0 0 1 0 0  1 7c0 12345678 0 0 0 c8caa005  # unmapped csr
00000013 400 0 0 0 1 8000000b  1 0 0 0 0 0 c8caa005  # interrupt
34102073 0 0 0 0 0 0  1 341 0 0 400 400 c8caa005
34202073 0 0 0 0 0 0  1 342 0 0 8000000b 400 c8caa005
34129073 800 0 0 1 1 80000007  1 341 12345678 0 400 400 c8caa005  # trap over csrrw mepc
34102073 0 0 0 0 0 0  1 341 0 0 800 800 c8caa005
34202073 0 0 0 0 0 0  1 342 0 0 80000007 800 c8caa005

//--- src/csr_file.sv
`timescale 1ns/100ps

module csr_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_isa_pkg::csr_addr_w-1:0] csr_addr,
    input  logic [rv_isa_pkg::funct3_w-1:0]   funct3,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_isa_pkg::xlen-1:0]       src1,
    input  logic                              csr_w_en,
    input  logic [rv_isa_pkg::xlen-1:0]       pc,
    input  logic                              is_intr,
    input  logic [rv_isa_pkg::xlen-1:0]       intr_code,
    output logic [rv_isa_pkg::xlen-1:0]       csr_r,
    output logic [rv_isa_pkg::xlen-1:0]       mepc,
    output logic [rv_isa_pkg::xlen-1:0]       mtvec
);

    logic [rv_isa_pkg::xlen-1:0] mstatus;
    logic [rv_isa_pkg::xlen-1:0] mcause;
    logic [rv_isa_pkg::xlen-1:0] operand;
    logic [rv_isa_pkg::xlen-1:0] csr_w;
    logic                        is_imm;
    rv_csr_pkg::csr_op_e         csr_op;

    assign csr_op = rv_csr_pkg::csr_op_e'(funct3[1:0]);
    assign is_imm = funct3[2];  // csrr*i forms

    // rs1 field is the 5-bit zimm for the immediate forms
    assign operand = is_imm ? {{(rv_isa_pkg::xlen-rv_isa_pkg::reg_addr_w){1'b0}}, rs1} : src1;

    always_comb begin
        case (csr_addr)
            rv_csr_pkg::csr_mstatus_addr: csr_r = mstatus;
            rv_csr_pkg::csr_mtvec_addr:   csr_r = mtvec;
            rv_csr_pkg::csr_mepc_addr:    csr_r = mepc;
            rv_csr_pkg::csr_mcause_addr:  csr_r = mcause;
            default:                      csr_r = '0;
        endcase
    end

    always_comb begin
        case (csr_op)
            rv_csr_pkg::csr_write: csr_w = operand;
            rv_csr_pkg::csr_set:   csr_w = csr_r | operand;
            rv_csr_pkg::csr_clear: csr_w = csr_r & ~operand;
            default:               csr_w = csr_r;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (is_intr) begin
            // trap wins over the instruction's write
            mepc   <= pc;
            mcause <= intr_code;
        end else if (csr_w_en) begin
            case (csr_addr)
                rv_csr_pkg::csr_mstatus_addr: mstatus <= csr_w;
                rv_csr_pkg::csr_mtvec_addr:   mtvec   <= csr_w;
                rv_csr_pkg::csr_mepc_addr:    mepc    <= csr_w;
                rv_csr_pkg::csr_mcause_addr:  mcause  <= csr_w;
                default: ;  // unknown address, dropped
            endcase
        end
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [rv_isa_pkg::xlen-1:0]     inst,
    input  logic [rv_isa_pkg::xlen-1:0]     pc,
    input  logic [rv_isa_pkg::xlen-1:0]     srd,
    input  logic                            gpr_w_en,
    input  logic                            csr_w_en,
    input  logic                            is_intr,
    input  logic [rv_isa_pkg::xlen-1:0]     intr_code,
    output rv_isa_pkg::inst_type_e          inst_type,
    output logic [rv_isa_pkg::xlen-1:0]     imm,
    output logic [rv_isa_pkg::opcode_w-1:0] opcode,
    output logic [rv_isa_pkg::funct3_w-1:0] funct3,
    output logic [rv_isa_pkg::funct7_w-1:0] funct7,
    output logic [rv_isa_pkg::xlen-1:0]     src1,
    output logic [rv_isa_pkg::xlen-1:0]     src2,
    output logic [rv_isa_pkg::xlen-1:0]     csr_r,
    output logic [rv_isa_pkg::xlen-1:0]     mepc,
    output logic [rv_isa_pkg::xlen-1:0]     mtvec
);

    logic [rv_isa_pkg::reg_addr_w-1:0] rd;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
    logic [rv_isa_pkg::csr_addr_w-1:0] csr_addr;

    inst_decoder inst_decoder_i (
        .inst     (inst),
        .inst_type(inst_type),
        .imm      (imm),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr_addr (csr_addr)
    );

    gpr_file gpr_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .srd     (srd),
        .gpr_w_en(gpr_w_en),
        .src1    (src1),
        .src2    (src2)
    );

    // src1 doubles as the csr register operand
    csr_file csr_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_addr (csr_addr),
        .funct3   (funct3),
        .rs1      (rs1),
        .src1     (src1),
        .csr_w_en (csr_w_en),
        .pc       (pc),
        .is_intr  (is_intr),
        .intr_code(intr_code),
        .csr_r    (csr_r),
        .mepc     (mepc),
        .mtvec    (mtvec)
    );

endmodule

//--- src/gpr_file.sv
`timescale 1ns/100ps

module gpr_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rd,
    input  logic [rv_isa_pkg::xlen-1:0]       srd,
    input  logic                              gpr_w_en,
    output logic [rv_isa_pkg::xlen-1:0]       src1,
    output logic [rv_isa_pkg::xlen-1:0]       src2
);

    // x0 has no storage
    logic [rv_isa_pkg::xlen-1:0] regs [1:rv_isa_pkg::gpr_count-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < rv_isa_pkg::gpr_count; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_w_en && rd != '0) begin
            regs[rd] <= srd;
        end
    end

    // no bypass, a write shows up the cycle after
    always_comb begin
        if (rs1 == '0) begin
            src1 = '0;
        end else begin
            src1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            src2 = '0;
        end else begin
            src2 = regs[rs2];
        end
    end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  logic [rv_isa_pkg::xlen-1:0]       inst,
    output rv_isa_pkg::inst_type_e            inst_type,
    output logic [rv_isa_pkg::xlen-1:0]       imm,
    output logic [rv_isa_pkg::opcode_w-1:0]   opcode,
    output logic [rv_isa_pkg::funct3_w-1:0]   funct3,
    output logic [rv_isa_pkg::funct7_w-1:0]   funct7,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rd,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_isa_pkg::csr_addr_w-1:0] csr_addr
);

    rv_isa_pkg::opcode_e opc;

    assign opcode   = inst[rv_isa_pkg::opcode_lsb +: rv_isa_pkg::opcode_w];
    assign rd       = inst[rv_isa_pkg::rd_lsb     +: rv_isa_pkg::reg_addr_w];
    assign funct3   = inst[rv_isa_pkg::funct3_lsb +: rv_isa_pkg::funct3_w];
    assign rs1      = inst[rv_isa_pkg::rs1_lsb    +: rv_isa_pkg::reg_addr_w];
    assign rs2      = inst[rv_isa_pkg::rs2_lsb    +: rv_isa_pkg::reg_addr_w];
    assign funct7   = inst[rv_isa_pkg::funct7_lsb +: rv_isa_pkg::funct7_w];
    assign csr_addr = inst[rv_isa_pkg::csr_lsb    +: rv_isa_pkg::csr_addr_w];

    assign opc = rv_isa_pkg::opcode_e'(opcode);

    // format from major opcode
    always_comb begin
        case (opc)
            rv_isa_pkg::opc_lui,
            rv_isa_pkg::opc_auipc:  inst_type = rv_isa_pkg::type_u;
            rv_isa_pkg::opc_jal:    inst_type = rv_isa_pkg::type_j;
            rv_isa_pkg::opc_jalr,
            rv_isa_pkg::opc_load,
            rv_isa_pkg::opc_op_imm,
            rv_isa_pkg::opc_system: inst_type = rv_isa_pkg::type_i;
            rv_isa_pkg::opc_branch: inst_type = rv_isa_pkg::type_b;
            rv_isa_pkg::opc_store:  inst_type = rv_isa_pkg::type_s;
            rv_isa_pkg::opc_op:     inst_type = rv_isa_pkg::type_r;
            default:                inst_type = rv_isa_pkg::type_none;
        endcase
    end

    // immediate, sign bit is always inst[31]
    always_comb begin
        case (inst_type)
            rv_isa_pkg::type_i: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            rv_isa_pkg::type_s: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            rv_isa_pkg::type_b: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_isa_pkg::type_u: begin
                imm = {inst[31:12], 12'b0};
            end
            rv_isa_pkg::type_j: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // r format and unknown opcodes
            end
        endcase
    end

endmodule

//--- src/rv_csr_pkg.sv
package rv_csr_pkg;

    // machine-mode csrs kept by this core
    localparam logic [rv_isa_pkg::csr_addr_w-1:0] csr_mstatus_addr = 12'h300;
    localparam logic [rv_isa_pkg::csr_addr_w-1:0] csr_mtvec_addr   = 12'h305;
    localparam logic [rv_isa_pkg::csr_addr_w-1:0] csr_mepc_addr    = 12'h341;
    localparam logic [rv_isa_pkg::csr_addr_w-1:0] csr_mcause_addr  = 12'h342;

    // funct3[1:0] of the zicsr instructions
    typedef enum logic [1:0] {
        csr_none  = 2'b00,
        csr_write = 2'b01,
        csr_set   = 2'b10,
        csr_clear = 2'b11
    } csr_op_e;

endpackage

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;
    localparam int gpr_count  = 1 << reg_addr_w;

    localparam int opcode_w = 7;
    localparam int funct3_w = 3;
    localparam int funct7_w = 7;

    // lsb of each instruction field
    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int csr_lsb    = 20;  // csr address shares bits with rs2/funct7
    localparam int funct7_lsb = 25;

    // rv32i major opcodes
    typedef enum logic [opcode_w-1:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        type_r    = 3'd0,
        type_i    = 3'd1,
        type_s    = 3'd2,
        type_b    = 3'd3,
        type_u    = 3'd4,
        type_j    = 3'd5,
        type_none = 3'd7   // unknown opcode
    } inst_type_e;

endpackage

//--- vlog.f
src/rv_isa_pkg.sv
src/rv_csr_pkg.sv
src/inst_decoder.sv
src/gpr_file.sv
src/csr_file.sv
src/decode_stage.sv
sim/decode_stage_sva.sv
sim/decode_stage_tb.sv
